// File: bench/issue_unit_properties.sv
`timescale 1ns/10ps

module issue_unit_properties (
    input logic                  clk,
    input logic                  rst_i,
    input logic                  rob_full_i,
    input logic                  alu_full_i,
    input logic                  cmp_full_i,
    input issue_pkg::rs_entry_t  alu_o,
    input issue_pkg::rs_entry_t  cmp_o,
    input issue_pkg::rob_alloc_t rob_o
);

    int violations = 0;

    one_station: assert property (@(posedge clk) disable iff (rst_i)
        !(alu_o.valid && cmp_o.valid))
    else begin
        violations++;
        $error("ALU and compare entries issued together");
    end

    rob_with_entry: assert property (@(posedge clk) disable iff (rst_i)
        rob_o.valid == (alu_o.valid || cmp_o.valid))
    else begin
        violations++;
        $error("ROB allocation and station entry out of step");
    end

    rob_tag_nonzero: assert property (@(posedge clk) disable iff (rst_i)
        rob_o.valid |-> rob_o.tag != '0)
    else begin
        violations++;
        $error("ROB allocation with tag 0");
    end

    // Outputs are registered, so the flag seen one edge earlier decides
    alu_held: assert property (@(posedge clk) disable iff (rst_i)
        alu_o.valid |-> !$past(alu_full_i))
    else begin
        violations++;
        $error("ALU entry issued while the ALU station was full");
    end

    cmp_held: assert property (@(posedge clk) disable iff (rst_i)
        cmp_o.valid |-> !$past(cmp_full_i))
    else begin
        violations++;
        $error("Compare entry issued while the compare station was full");
    end

    rob_held: assert property (@(posedge clk) disable iff (rst_i)
        rob_o.valid |-> !$past(rob_full_i))
    else begin
        violations++;
        $error("ROB allocation while the ROB was full");
    end

endmodule

bind issue_unit_top issue_unit_properties issue_unit_properties_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .rob_full_i (rob_full_i),
    .alu_full_i (alu_full_i),
    .cmp_full_i (cmp_full_i),
    .alu_o      (alu_o),
    .cmp_o      (cmp_o),
    .rob_o      (rob_o)
);

// File: bench/issue_unit_tb.sv
`timescale 1ns/10ps

module issue_unit_tb;

    typedef struct packed {
        logic [1:0]          kind;  // 0 instruction, 1 commit, 2 full flag
        logic [31:0]         pc;
        logic [31:0]         instr;
        logic [2:0]          tag;
        logic [1:0]          unit;  // 0 ALU, 1 compare, 2 dropped
        logic [2:0]          op;
        issue_pkg::operand_t op1;
        issue_pkg::operand_t op2;
        logic                bypass;
        logic [4:0]          rd;
        logic [31:0]         value;
        logic [1:0]          flag;
        logic [7:0]          cycles;
    } record_t;

    typedef struct packed {
        logic                  to_cmp;
        issue_pkg::rs_entry_t  entry;
        issue_pkg::rob_alloc_t rob;
    } expect_t;

    logic                        clk = 1'b0;
    logic                        rst_i;
    logic                        instr_valid_i;
    issue_pkg::instr_pkt_t       instr_i;
    logic                        instr_ready_o;
    issue_pkg::commit_t          commit_i;
    logic [issue_pkg::TAG_W-1:0] rob_tag_i;
    logic                        rob_full_i;
    logic                        alu_full_i;
    logic                        cmp_full_i;
    issue_pkg::rs_entry_t        alu_o;
    issue_pkg::rs_entry_t        cmp_o;
    issue_pkg::rob_alloc_t       rob_o;

    record_t            records[$];
    expect_t            expected_q[$];
    logic [2:0]         tag_q[$];   // ROB tags of instructions not yet issued
    int                 hold[3];    // Remaining full cycles: alu, cmp, rob
    int                 value_errors = 0;
    int                 other_errors = 0;
    int                 checks = 0;
    int                 stall_cycles = 0;
    int                 cycle_count = 0;
    int                 cycle_limit = 0;
    bit                 saw_flags = 1'b0;
    issue_pkg::commit_t pending_commit;

    issue_unit_top issue_unit_top_inst (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: no progress within %0d cycles", cycle_limit);
            report_counts();
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [2:0] op_from_name(input logic [63:0] name);
        case (name)
            "add":   return issue_pkg::alu_add;
            "sub":   return issue_pkg::alu_sub;
            "sll":   return issue_pkg::alu_sll;
            "xor":   return issue_pkg::alu_xor;
            "srl":   return issue_pkg::alu_srl;
            "sra":   return issue_pkg::alu_sra;
            "or":    return issue_pkg::alu_or;
            "and":   return issue_pkg::alu_and;
            "lt":    return {2'b00, issue_pkg::cmp_lt};
            "ltu":   return {2'b00, issue_pkg::cmp_ltu};
            default: return 3'bxxx;
        endcase
    endfunction

    function automatic logic [1:0] index_from_name(input logic [63:0] name);
        case (name)
            "alu":   return 2'd0;
            "cmp":   return 2'd1;
            "rob":   return 2'd2;
            default: return 2'd2;  // none
        endcase
    endfunction

    function void apply_flags();
        alu_full_i = (hold[0] != 0);
        cmp_full_i = (hold[1] != 0);
        rob_full_i = (hold[2] != 0);
    endfunction

    task automatic report_counts();
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
    endtask

    task automatic read_records();
        int               fd;
        int               tag, r1, t1, r2, t2, bypass, rd, cyc;
        logic [63:0]      word, unit_name, op_name;
        logic [31:0]      pc, instr, v1, v2, value;
        logic [8*160-1:0] rest;
        record_t          rec;
        fd = $fopen("bench/issue_unit_testdata.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open the stimulus file bench/issue_unit_testdata.txt");
            return;
        end
        while ($fscanf(fd, "%s", word) == 1) begin
            rec = '0;
            if (word == "#") begin
                void'($fgets(rest, fd));
                continue;
            end else if (word == "I") begin
                void'($fscanf(fd, "%h %h %d %s %s %h %d %d %h %d %d", pc, instr, tag,
                              unit_name, op_name, v1, r1, t1, v2, r2, t2));
                rec.kind  = 2'd0;
                rec.pc    = pc;
                rec.instr = instr;
                rec.tag   = tag[2:0];
                rec.unit  = index_from_name(unit_name);
                rec.op    = op_from_name(op_name);
                rec.op1   = {v1, r1[0], t1[2:0]};
                rec.op2   = {v2, r2[0], t2[2:0]};
            end else if (word == "C") begin
                void'($fscanf(fd, "%d %d %d %h", bypass, rd, tag, value));
                rec.kind   = 2'd1;
                rec.bypass = bypass[0];
                rec.rd     = rd[4:0];
                rec.tag    = tag[2:0];
                rec.value  = value;
            end else begin
                void'($fscanf(fd, "%s %d", unit_name, cyc));
                rec.kind   = 2'd2;
                rec.flag   = index_from_name(unit_name);
                rec.cycles = cyc[7:0];
            end
            records.push_back(rec);
        end
        $fclose(fd);
    endtask

    // One clock cycle, monitor and back-pressure at the falling edge
    task automatic step();
        expect_t              exp;
        issue_pkg::rs_entry_t got;
        @(negedge clk);
        if (alu_o.valid || cmp_o.valid || rob_o.valid) begin
            checks++;
            if (expected_q.size() == 0) begin
                other_errors++;
                $display("Unexpected issue at %0t with no instruction pending", $time);
            end else begin
                exp = expected_q.pop_front();
                void'(tag_q.pop_front());
                got = exp.to_cmp ? cmp_o : alu_o;
                assert (got.valid && !(alu_o.valid && cmp_o.valid)) else begin
                    other_errors++;
                    $display("Instruction at pc %h went to the wrong station", exp.rob.pc);
                end
                assert (got == exp.entry) else begin
                    value_errors++;
                    $display("Fail %0t: station entry %h, expected %h", $time, got, exp.entry);
                end
                assert (rob_o == exp.rob) else begin
                    value_errors++;
                    $display("Fail %0t: ROB allocation %h, expected %h", $time, rob_o, exp.rob);
                end
            end
        end
        for (int i = 0; i < 3; i++) begin
            if (hold[i] > 0)
                hold[i]--;
        end
        apply_flags();
        rob_tag_i = (tag_q.size() != 0) ? tag_q[0] : 3'd1;  // ROB never hands out 0
    endtask

    task automatic wait_idle();
        while (expected_q.size() != 0)
            step();
    endtask

    task automatic send_instr(input record_t rec);
        expect_t exp;
        if (rec.unit != 2'd2) begin
            exp.to_cmp = rec.unit[0];
            exp.entry  = {1'b1, rec.op, rec.op1, rec.op2, rec.tag};
            exp.rob    = {1'b1, rec.pc, rec.instr[11:7], rec.tag};
            expected_q.push_back(exp);
            tag_q.push_back(rec.tag);
            rob_tag_i = tag_q[0];
        end
        instr_valid_i = 1'b1;
        instr_i       = {rec.pc, rec.instr};
        #1;
        while (!instr_ready_o) begin
            stall_cycles++;
            step();
            #1;
        end
        step();
        instr_valid_i = 1'b0;
        // Instruction now sits in decode, commit lands on its dispatch cycle
        if (pending_commit.valid) begin
            commit_i       = pending_commit;
            pending_commit = '0;
            step();
            commit_i = '0;
        end
    endtask

    task automatic run_record(input record_t rec);
        case (rec.kind)
            2'd0: send_instr(rec);
            2'd1: begin
                if (rec.bypass) begin
                    pending_commit = {1'b1, rec.rd, rec.tag, rec.value};
                end else begin
                    wait_idle();
                    commit_i = {1'b1, rec.rd, rec.tag, rec.value};
                    step();
                    commit_i = '0;
                end
            end
            default: begin
                saw_flags      = 1'b1;
                hold[rec.flag] = rec.cycles;
                apply_flags();
            end
        endcase
    endtask

    initial begin
        void'($urandom(31));
        rst_i          = 1'b1;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        commit_i       = '0;
        pending_commit = '0;
        rob_tag_i      = 3'd1;
        rob_full_i     = 1'b0;
        alu_full_i     = 1'b0;
        cmp_full_i     = 1'b0;
        read_records();
        cycle_limit = 40 * records.size() + 100;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        #1;
        assert (instr_ready_o && !alu_o.valid && !cmp_o.valid && !rob_o.valid) else begin
            other_errors++;
            $display("Outputs are not idle after reset");
        end
        foreach (records[i]) begin
            repeat ($urandom % 3) step();  // Random gap between records
            run_record(records[i]);
        end
        wait_idle();
        repeat (4) step();
        assert (!saw_flags || stall_cycles > 0) else begin
            other_errors++;
            $display("Back-pressure never held an instruction at the input");
        end
        other_errors += issue_unit_top_inst.issue_unit_properties_inst.violations;
        report_counts();
        if (value_errors + other_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: bench/issue_unit_testdata.txt
# I pc instr rob_tag unit op op1_value op1_ready op1_tag op2_value op2_ready op2_tag
# C bypass rd tag value, F flag cycles; pc, instr and values in hex
C 0 1 0 00000010
C 0 2 0 00000003
I 00000100 00508193 1 alu add 00000010 1 0 00000005 1 0
I 00000104 40208233 2 alu sub 00000010 1 0 00000003 1 0
I 00000108 004182B3 3 alu add 00000000 0 1 00000000 0 2
C 0 3 1 00000015
I 0000010C FFF1C313 4 alu xor 00000015 1 0 FFFFFFFF 1 0
C 1 4 2 0000000D
I 00000110 001223B3 5 cmp lt 0000000D 1 0 00000010 1 0
I 00000114 00100293 6 alu add 00000000 1 0 00000001 1 0
C 0 5 3 00000022
I 00000118 0022B433 7 cmp ltu 00000022 0 6 00000003 1 0
I 0000011C 0200A493 1 cmp lt 00000010 1 0 00000020 1 0
I 00000120 FFF13513 2 cmp ltu 00000003 1 0 FFFFFFFF 1 0
I 00000124 00108013 3 none add 00000000 0 0 00000000 0 0
I 00000128 0000A583 3 none add 00000000 0 0 00000000 0 0
I 0000012C 123455B7 3 alu add 00000000 1 0 12345000 1 0
I 00000130 00001617 4 alu add 00000130 1 0 00001000 1 0
F alu 10
I 00000134 4020D693 5 alu sra 00000010 1 0 00000402 1 0
I 00000138 0016E733 6 alu or 00000000 0 5 00000010 1 0
F cmp 10
I 0000013C 009727B3 7 cmp lt 00000000 0 6 00000000 0 1
F rob 8
I 00000140 0020F833 1 alu and 00000010 1 0 00000003 1 0
I 00000144 001118B3 2 alu sll 00000003 1 0 00000010 1 0
I 00000148 0010D913 3 alu srl 00000010 1 0 00000001 1 0

// File: verilog/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  instr_valid_i,
    input  issue_pkg::instr_pkt_t instr_i,
    output logic                  instr_ready_o,
    input  logic                  dec_ready_i,
    output issue_pkg::decoded_t   dec_o
);

    // funct3 to ALU op, sub_sel only honoured for OP
    function automatic issue_pkg::alu_op_e alu_op_of(input logic [2:0] f3,
                                                     input logic sub_sel,
                                                     input logic sra_sel);
        case (f3)
            3'b000:  return sub_sel ? issue_pkg::alu_sub : issue_pkg::alu_add;
            3'b101:  return sra_sel ? issue_pkg::alu_sra : issue_pkg::alu_srl;
            default: return issue_pkg::alu_op_e'(f3);
        endcase
    endfunction

    issue_pkg::rv32_opcode_e     opcode;
    logic [2:0]                  funct3;
    logic                        funct7_b5;
    logic [issue_pkg::REG_W-1:0] rd, rs1, rs2;
    logic [issue_pkg::XLEN-1:0]  i_imm, u_imm;
    logic                        is_slt;
    logic                        supported;
    issue_pkg::decoded_t         dec_n;

    assign opcode    = issue_pkg::rv32_opcode_e'(instr_i.instr[6:0]);
    assign funct3    = instr_i.instr[14:12];
    assign funct7_b5 = instr_i.instr[30];
    assign rd        = instr_i.instr[11:7];
    assign rs1       = instr_i.instr[19:15];
    assign rs2       = instr_i.instr[24:20];
    assign i_imm     = {{20{instr_i.instr[31]}}, instr_i.instr[31:20]};
    assign u_imm     = {instr_i.instr[31:12], 12'h000};
    assign is_slt    = (funct3[2:1] == 2'b01);  // SLT and SLTU

    always_comb begin
        dec_n        = '0;
        supported    = 1'b1;
        dec_n.pc     = instr_i.pc;
        dec_n.rd     = rd;
        dec_n.imm2   = i_imm;
        dec_n.unit   = issue_pkg::unit_alu;
        dec_n.alu_op = issue_pkg::alu_add;
        dec_n.cmp_op = funct3[0] ? issue_pkg::cmp_ltu : issue_pkg::cmp_lt;
        case (opcode)
            issue_pkg::op_lui: begin
                dec_n.imm2 = u_imm;  // 0 + imm
            end
            issue_pkg::op_auipc: begin
                dec_n.imm1 = instr_i.pc;
                dec_n.imm2 = u_imm;
            end
            issue_pkg::op_imm: begin
                dec_n.rs1         = rs1;
                dec_n.src1_is_reg = 1'b1;
                dec_n.alu_op      = alu_op_of(funct3, 1'b0, funct7_b5);
                if (is_slt)
                    dec_n.unit = issue_pkg::unit_cmp;
            end
            issue_pkg::op_reg: begin
                dec_n.rs1         = rs1;
                dec_n.rs2         = rs2;
                dec_n.src1_is_reg = 1'b1;
                dec_n.src2_is_reg = 1'b1;
                dec_n.alu_op      = alu_op_of(funct3, funct7_b5, funct7_b5);
                if (is_slt)
                    dec_n.unit = issue_pkg::unit_cmp;
            end
            default: supported = 1'b0;
        endcase
        // x0 writes and unknown opcodes are swallowed here
        dec_n.valid = instr_valid_i && supported && (rd != '0);
    end

    assign instr_ready_o = dec_ready_i;  // Empty or draining

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_o.valid <= 1'b0;
        end else if (dec_ready_i) begin
            dec_o <= dec_n;
        end
    end

endmodule

// File: verilog/dispatch_stage.sv
`timescale 1ns/10ps

module dispatch_stage (
    input  logic                        clk,
    input  logic                        rst_i,
    input  issue_pkg::decoded_t         dec_i,
    output logic                        dec_ready_o,
    output logic [issue_pkg::REG_W-1:0] rs1_o,
    output logic [issue_pkg::REG_W-1:0] rs2_o,
    input  issue_pkg::operand_t         op1_i,
    input  issue_pkg::operand_t         op2_i,
    output logic                        rename_en_o,
    output logic [issue_pkg::REG_W-1:0] rename_rd_o,
    output logic [issue_pkg::TAG_W-1:0] rename_tag_o,
    input  logic [issue_pkg::TAG_W-1:0] rob_tag_i,
    input  logic                        rob_full_i,
    input  logic                        alu_full_i,
    input  logic                        cmp_full_i,
    output issue_pkg::rs_entry_t        alu_o,
    output issue_pkg::rs_entry_t        cmp_o,
    output issue_pkg::rob_alloc_t       rob_o
);

    logic                   to_cmp;
    logic                   target_full;
    logic                   issue;
    issue_pkg::operand_t    src1, src2;
    issue_pkg::rs_entry_t   entry_n;
    issue_pkg::rob_alloc_t  rob_n;

    // Table lookup happens here, same cycle as the rename
    assign rs1_o = dec_i.rs1;
    assign rs2_o = dec_i.rs2;

    assign src1 = dec_i.src1_is_reg ? op1_i :
                  issue_pkg::operand_t'{value: dec_i.imm1, ready: 1'b1, tag: '0};
    assign src2 = dec_i.src2_is_reg ? op2_i :
                  issue_pkg::operand_t'{value: dec_i.imm2, ready: 1'b1, tag: '0};

    assign to_cmp      = (dec_i.unit == issue_pkg::unit_cmp);
    assign target_full = to_cmp ? cmp_full_i : alu_full_i;
    assign issue       = dec_i.valid && !rob_full_i && !target_full;
    assign dec_ready_o = !dec_i.valid || issue;

    assign rename_en_o  = issue;
    assign rename_rd_o  = dec_i.rd;
    assign rename_tag_o = rob_tag_i;

    always_comb begin
        entry_n.valid   = 1'b1;
        entry_n.op      = to_cmp ? {2'b00, dec_i.cmp_op} : dec_i.alu_op;
        entry_n.op1     = src1;
        entry_n.op2     = src2;
        entry_n.rob_tag = rob_tag_i;

        rob_n.valid = 1'b1;
        rob_n.pc    = dec_i.pc;
        rob_n.rd    = dec_i.rd;
        rob_n.tag   = rob_tag_i;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            alu_o.valid <= 1'b0;
            cmp_o.valid <= 1'b0;
            rob_o.valid <= 1'b0;
        end else begin
            // Single cycle pulses
            alu_o.valid <= 1'b0;
            cmp_o.valid <= 1'b0;
            rob_o.valid <= 1'b0;
            if (issue) begin
                rob_o <= rob_n;
                if (to_cmp)
                    cmp_o <= entry_n;
                else
                    alu_o <= entry_n;
            end
        end
    end

endmodule

// File: verilog/issue_pkg.sv
package issue_pkg;

    localparam int XLEN     = 32;
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;
    localparam int TAG_W    = 3;  // Tag 0 means no producer

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32_opcode_e;

    // Encoding follows funct3 where it can
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_e;

    typedef enum logic {
        cmp_lt  = 1'b0,
        cmp_ltu = 1'b1
    } cmp_op_e;

    typedef enum logic {
        unit_alu = 1'b0,
        unit_cmp = 1'b1
    } issue_unit_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } instr_pkt_t;

    typedef struct packed {
        logic              valid;
        issue_unit_e       unit;
        alu_op_e           alu_op;
        cmp_op_e           cmp_op;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs1;
        logic [REG_W-1:0]  rs2;
        logic              src1_is_reg;
        logic              src2_is_reg;
        logic [XLEN-1:0]   imm1;  // pc or zero
        logic [XLEN-1:0]   imm2;
        logic [XLEN-1:0]   pc;    // For the ROB entry
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0]   value;
        logic              ready;
        logic [TAG_W-1:0]  tag;
    } operand_t;

    // Shared by the ALU and compare stations
    typedef struct packed {
        logic              valid;
        logic [2:0]        op;  // alu_op_e, or cmp_op_e zero extended
        operand_t          op1;
        operand_t          op2;
        logic [TAG_W-1:0]  rob_tag;
    } rs_entry_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_W-1:0]  rd;
        logic [TAG_W-1:0]  tag;
    } rob_alloc_t;

    typedef struct packed {
        logic              valid;
        logic [REG_W-1:0]  rd;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   value;
    } commit_t;

endpackage

// File: verilog/issue_unit_top.sv
`timescale 1ns/10ps

module issue_unit_top (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        instr_valid_i,
    input  issue_pkg::instr_pkt_t       instr_i,
    output logic                        instr_ready_o,
    input  issue_pkg::commit_t          commit_i,
    input  logic [issue_pkg::TAG_W-1:0] rob_tag_i,
    input  logic                        rob_full_i,
    input  logic                        alu_full_i,
    input  logic                        cmp_full_i,
    output issue_pkg::rs_entry_t        alu_o,
    output issue_pkg::rs_entry_t        cmp_o,
    output issue_pkg::rob_alloc_t       rob_o
);

    issue_pkg::decoded_t         dec;
    logic                        dec_ready;
    logic [issue_pkg::REG_W-1:0] rs1, rs2;
    issue_pkg::operand_t         op1, op2;
    logic                        rename_en;
    logic [issue_pkg::REG_W-1:0] rename_rd;
    logic [issue_pkg::TAG_W-1:0] rename_tag;

    decode_stage decode_stage_inst (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .dec_ready_i   (dec_ready),
        .dec_o         (dec)
    );

    dispatch_stage dispatch_stage_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .dec_i        (dec),
        .dec_ready_o  (dec_ready),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .op1_i        (op1),
        .op2_i        (op2),
        .rename_en_o  (rename_en),
        .rename_rd_o  (rename_rd),
        .rename_tag_o (rename_tag),
        .rob_tag_i    (rob_tag_i),
        .rob_full_i   (rob_full_i),
        .alu_full_i   (alu_full_i),
        .cmp_full_i   (cmp_full_i),
        .alu_o        (alu_o),
        .cmp_o        (cmp_o),
        .rob_o        (rob_o)
    );

    reg_status_table reg_status_table_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .op1_o        (op1),
        .op2_o        (op2),
        .rename_en_i  (rename_en),
        .rename_rd_i  (rename_rd),
        .rename_tag_i (rename_tag),
        .commit_i     (commit_i)
    );

endmodule

// File: verilog/reg_status_table.sv
`timescale 1ns/10ps

module reg_status_table (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic [issue_pkg::REG_W-1:0] rs1_i,
    input  logic [issue_pkg::REG_W-1:0] rs2_i,
    output issue_pkg::operand_t         op1_o,
    output issue_pkg::operand_t         op2_o,
    input  logic                        rename_en_i,
    input  logic [issue_pkg::REG_W-1:0] rename_rd_i,
    input  logic [issue_pkg::TAG_W-1:0] rename_tag_i,
    input  issue_pkg::commit_t          commit_i
);

    logic [issue_pkg::XLEN-1:0]  value_q [issue_pkg::NUM_REGS];
    logic [issue_pkg::TAG_W-1:0] tag_q [issue_pkg::NUM_REGS];
    logic [issue_pkg::REG_W-1:0] rd_idx [2];
    issue_pkg::operand_t         rd_op [2];

    assign rd_idx[0] = rs1_i;
    assign rd_idx[1] = rs2_i;
    assign op1_o     = rd_op[0];
    assign op2_o     = rd_op[1];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < issue_pkg::NUM_REGS; i++) begin
                value_q[i] <= '0;
                tag_q[i]   <= '0;
            end
        end else begin
            for (int i = 1; i < issue_pkg::NUM_REGS; i++) begin
                if (commit_i.valid && commit_i.rd == issue_pkg::REG_W'(i)) begin
                    value_q[i] <= commit_i.value;
                    // Stale commit keeps the newer producer
                    if (tag_q[i] == commit_i.tag)
                        tag_q[i] <= '0;
                end
                if (rename_en_i && rename_rd_i == issue_pkg::REG_W'(i))
                    tag_q[i] <= rename_tag_i;  // Rename beats commit clear
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_op[p].value = value_q[rd_idx[p]];
            rd_op[p].tag   = tag_q[rd_idx[p]];
            // Commit bypass
            if (rd_op[p].tag != '0 && commit_i.valid && commit_i.tag == rd_op[p].tag) begin
                rd_op[p].value = commit_i.value;
                rd_op[p].tag   = '0;
            end
            if (rd_idx[p] == '0) begin
                rd_op[p].value = '0;
                rd_op[p].tag   = '0;
            end
            rd_op[p].ready = (rd_op[p].tag == '0);
        end
    end

endmodule

// File: vlog.f
verilog/issue_pkg.sv
verilog/decode_stage.sv
verilog/reg_status_table.sv
verilog/dispatch_stage.sv
verilog/issue_unit_top.sv
bench/issue_unit_properties.sv
bench/issue_unit_tb.sv
